//--- src/he_null_pkg.sv
// Single-beat MMIO only; request header is 192 bits so all listed fields fit, completion header 128
package he_null_pkg;

   // --------------------------------------------------------------------------
   // Function identity and request codes
   // --------------------------------------------------------------------------
   localparam logic [2:0]  PF_ID = 3'd3;
   localparam logic [10:0] VF_ID = 11'd0;

   localparam logic [7:0] REQ_PU_RD = 8'h20;  // Power-user memory read
   localparam logic [7:0] REQ_PU_WR = 8'h60;  // Power-user memory write
   localparam logic [7:0] REQ_DM_RD = 8'h21;  // Data-mover memory read
   localparam logic [7:0] REQ_DM_WR = 8'h61;  // Data-mover memory write
   localparam logic [7:0] CPL_DM    = 8'h4a;  // Completion with data

   // CSR byte offsets, 8-byte aligned
   localparam logic [13:0] CSR_DFH     = 14'h0000;
   localparam logic [13:0] CSR_GUID_L  = 14'h0008;
   localparam logic [13:0] CSR_GUID_H  = 14'h0010;
   localparam logic [13:0] CSR_SCRATCH = 14'h0018;

   // Feature header: type 1, end of list, no next offset
   localparam logic [63:0] FEATURE_DFH_WORD = {4'h1, 19'h0, 1'b1, 24'h0, 4'h0, 12'h0};
   localparam logic [63:0] NULL_GUID_L      = 64'haa31_f54a_3e40_3501;
   localparam logic [63:0] NULL_GUID_H      = 64'h3e7b_60a0_df2d_4850;
   localparam logic [31:0] DEBUG_RESET_WORD = 32'hdead_beef;

   // Debug marks left by a write to an unmapped offset
   localparam logic [63:0] UNMAPPED_SCRATCH_WORD = 64'h0000_0000_aaaa_aaaa;
   localparam logic [31:0] UNMAPPED_DEBUG_WORD   = 32'hbbbb_bbbb;

   // --------------------------------------------------------------------------
   // Address field, two decodes of the same 64 bits
   // --------------------------------------------------------------------------
   typedef struct packed {
      logic [17:0] rsvd_h;
      logic [11:0] dw_addr;    // High word bits 13:2
      logic [1:0]  rsvd_m;
      logic [31:0] addr_l;
   } mmio_addr_pu_t;

   typedef struct packed {
      logic [31:0] addr_h;
      logic [19:0] rsvd_l;
      logic [11:0] dw_addr;    // Low word bits 11:0
   } mmio_addr_dm_t;

   typedef union packed {
      mmio_addr_pu_t pu;
      mmio_addr_dm_t dm;
   } mmio_addr_u;

   typedef struct packed {
      logic [7:0]  req_code;
      logic [9:0]  length;     // Dwords
      logic [9:0]  tag;
      logic [15:0] req_id;
      logic [2:0]  pf_num;
      logic [10:0] vf_num;
      logic        vf_active;
      logic [2:0]  tc;
      logic [2:0]  attr;
      mmio_addr_u  addr;
      logic [62:0] rsvd;
   } mmio_req_hdr_t;

   typedef struct packed {
      logic [7:0]  cpl_code;
      logic [2:0]  status;
      logic [9:0]  length;
      logic [11:0] byte_count;
      logic [9:0]  tag;
      logic [15:0] req_id;
      logic [15:0] cmpl_id;
      logic [2:0]  pf_num;
      logic [10:0] vf_num;
      logic        vf_active;
      logic [2:0]  tc;
      logic [2:0]  attr;
      logic [15:0] lower_addr;
      logic [15:0] rsvd;
   } mmio_cpl_hdr_t;

   // Stream beats and the decoded request
   typedef struct packed {
      logic          valid;
      logic          last;
      mmio_req_hdr_t hdr;
      logic [63:0]   data;
   } mmio_rx_beat_t;

   typedef struct packed {
      logic          rd;         // Already qualified by function hit
      logic          wr;
      logic [13:0]   offset;     // 8-byte aligned CSR offset
      logic          upper32;
      logic [63:0]   wdata;
      mmio_req_hdr_t hdr;
   } mmio_req_t;

   typedef struct packed {
      logic          valid;
      logic          last;
      mmio_cpl_hdr_t hdr;
      logic [63:0]   data;
   } mmio_cpl_t;

   // Dword address, view picked by request code
   function automatic logic [11:0] req_dw_addr(input mmio_req_hdr_t hdr);
      logic pu_view;
      pu_view = (hdr.req_code == REQ_PU_RD) || (hdr.req_code == REQ_PU_WR);
      return pu_view ? hdr.addr.pu.dw_addr : hdr.addr.dm.dw_addr;
   endfunction

endpackage

//--- src/mmio_rx_unpack.sv
// Only start-of-packet beats are decoded; later beats of a packet are accepted and dropped
`timescale 1ns/1ps

module mmio_rx_unpack (
   input  logic                       clk,
   input  logic                       rst_n,
   input  he_null_pkg::mmio_rx_beat_t i_rx,
   input  logic                       i_rx_ready,
   output he_null_pkg::mmio_req_t     o_req
);
   import he_null_pkg::*;

   logic          rx_fire;
   logic          r_next_sop;     // Next accepted beat opens a packet
   logic          r_acc;          // Registered beat is a fresh accept
   logic          r_acc_sop;
   mmio_req_hdr_t r_hdr;
   logic [63:0]   r_data;
   logic [11:0]   dw_addr;
   logic          func_hit;
   logic          code_rd;
   logic          code_wr;

   assign rx_fire = i_rx.valid & i_rx_ready;

   // --------------------------------------------------------------------------
   // Beat capture and packet framing
   // --------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_next_sop <= 1'b1;
         r_acc      <= 1'b0;
         r_acc_sop  <= 1'b0;
      end else begin
         r_acc <= rx_fire;
         if (rx_fire) begin
            r_acc_sop  <= r_next_sop;
            r_next_sop <= i_rx.last;    // Packet ends on last
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_fire) begin
         r_hdr  <= i_rx.hdr;
         r_data <= i_rx.data;
      end
   end

   // --------------------------------------------------------------------------
   // Decode of the registered header
   // --------------------------------------------------------------------------
   always_comb begin
      dw_addr  = req_dw_addr(r_hdr);

      // PF match when not virtual, VF match when virtual
      func_hit = r_hdr.vf_active ? (r_hdr.vf_num == VF_ID) : (r_hdr.pf_num == PF_ID);

      code_rd  = (r_hdr.req_code == REQ_PU_RD) || (r_hdr.req_code == REQ_DM_RD);
      code_wr  = (r_hdr.req_code == REQ_PU_WR) || (r_hdr.req_code == REQ_DM_WR);

      o_req.rd      = r_acc & r_acc_sop & func_hit & code_rd;
      o_req.wr      = r_acc & r_acc_sop & func_hit & code_wr;
      o_req.offset  = {dw_addr[11:1], 3'b000};
      o_req.upper32 = (r_hdr.length == 10'd1) & dw_addr[0];   // Odd dword, single dword
      o_req.wdata   = r_data;
      o_req.hdr     = r_hdr;
   end

endmodule

//--- src/mmio_csr_file.sv
// Four mapped 8-byte CSRs; any other offset reads the debug word and is a debug write target
`timescale 1ns/1ps

module mmio_csr_file (
   input  logic                   clk,
   input  logic                   rst_n,
   input  he_null_pkg::mmio_req_t i_req,
   input  logic                   i_flr_rst_n,
   output logic [63:0]            o_rd_data,
   output logic                   o_flr_ack
);
   import he_null_pkg::*;

   logic [63:0] r_scratch;
   logic [31:0] r_debug;
   logic        r_flr_s1;     // Latest function-reset sample
   logic        r_flr_s2;     // Sample before that
   logic [63:0] csr_word;
   logic        csr_hit;

   // --------------------------------------------------------------------------
   // Writes
   // --------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_scratch <= '0;
         r_debug   <= DEBUG_RESET_WORD;
      end else if (i_req.wr) begin
         if (i_req.offset == CSR_SCRATCH) begin
            if (i_req.upper32) begin
               r_scratch <= {2{i_req.wdata[31:0]}};   // Dword lands in both halves
            end else begin
               r_scratch <= i_req.wdata;
            end
         end else begin
            // Unmapped write leaves a visible mark
            r_scratch <= UNMAPPED_SCRATCH_WORD;
            r_debug   <= UNMAPPED_DEBUG_WORD;
         end
      end
   end

   // --------------------------------------------------------------------------
   // Read word, combinational from the registered request
   // --------------------------------------------------------------------------
   always_comb begin
      csr_hit = 1'b1;
      case (i_req.offset)
         CSR_DFH:     csr_word = FEATURE_DFH_WORD;
         CSR_GUID_L:  csr_word = NULL_GUID_L;
         CSR_GUID_H:  csr_word = NULL_GUID_H;
         CSR_SCRATCH: csr_word = r_scratch;
         default: begin
            csr_word = '0;
            csr_hit  = 1'b0;
         end
      endcase

      if (!csr_hit) begin
         o_rd_data = {r_debug, 1'b0, 17'h0, i_req.offset};   // Debug word over the address
      end else if (i_req.upper32) begin
         o_rd_data = {32'h0, csr_word[63:32]};             // Upper half in the low lane
      end else begin
         o_rd_data = csr_word;
      end
   end

   // Function reset, ack one cycle after the falling sample
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_flr_s1  <= 1'b1;
         r_flr_s2  <= 1'b1;
         o_flr_ack <= 1'b0;
      end else begin
         r_flr_s1  <= i_flr_rst_n;
         r_flr_s2  <= r_flr_s1;
         o_flr_ack <= r_flr_s2 & ~r_flr_s1;
      end
   end

endmodule

//--- src/mmio_cpl_hdr_gen.sv
// Completion is always successful and one beat of 1 or 2 dwords
`timescale 1ns/1ps

module mmio_cpl_hdr_gen (
   input  he_null_pkg::mmio_req_t     i_req,
   output he_null_pkg::mmio_cpl_hdr_t o_cpl_hdr
);
   import he_null_pkg::*;

   logic [11:0] dw_addr;
   logic        one_dw;

   // --------------------------------------------------------------------------
   // Header fields
   // --------------------------------------------------------------------------
   always_comb begin
      dw_addr = req_dw_addr(i_req.hdr);
      one_dw  = (i_req.hdr.length == 10'd1);

      o_cpl_hdr            = '0;
      o_cpl_hdr.cpl_code   = CPL_DM;
      o_cpl_hdr.status     = 3'h0;                          // Successful
      o_cpl_hdr.length     = one_dw ? 10'd1 : 10'd2;        // Dwords
      o_cpl_hdr.byte_count = one_dw ? 12'd4 : 12'd8;

      // Echo the requester context
      o_cpl_hdr.tag        = i_req.hdr.tag;
      o_cpl_hdr.req_id     = i_req.hdr.req_id;
      o_cpl_hdr.tc         = i_req.hdr.tc;
      o_cpl_hdr.attr       = i_req.hdr.attr;
      o_cpl_hdr.vf_active  = i_req.hdr.vf_active;

      // This port as completer
      o_cpl_hdr.pf_num     = PF_ID;
      o_cpl_hdr.vf_num     = VF_ID;
      o_cpl_hdr.cmpl_id    = {1'b0, VF_ID, i_req.hdr.vf_active, PF_ID};

      o_cpl_hdr.lower_addr = {2'b00, dw_addr, 2'b00};      // Byte address
   end

endmodule

//--- src/mmio_tx_stage.sv
// One-entry completion slot; receive side stalls while a read is in flight to the slot
`timescale 1ns/1ps

module mmio_tx_stage (
   input  logic                       clk,
   input  logic                       rst_n,
   input  he_null_pkg::mmio_req_t     i_req,
   input  he_null_pkg::mmio_cpl_hdr_t i_cpl_hdr,
   input  logic [63:0]                i_rd_data,
   input  logic                       i_tx_ready,
   output he_null_pkg::mmio_cpl_t     o_tx,
   output logic                       o_rx_ready
);
   import he_null_pkg::*;

   logic          r_live;      // Out of reset
   logic          r_valid;
   mmio_cpl_hdr_t r_hdr;
   logic [63:0]   r_data;
   logic          tx_drain;

   assign tx_drain = r_valid & i_tx_ready;

   // --------------------------------------------------------------------------
   // Slot control
   // --------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_live  <= 1'b0;
         r_valid <= 1'b0;
      end else begin
         r_live <= 1'b1;
         if (i_req.rd) begin
            r_valid <= 1'b1;     // Slot is free whenever a read strobe arrives
         end else if (tx_drain) begin
            r_valid <= 1'b0;
         end
      end
   end

   // Header and data held stable until drained
   always_ff @(posedge clk) begin
      if (i_req.rd) begin
         r_hdr  <= i_cpl_hdr;
         r_data <= i_rd_data;
      end
   end

   always_comb begin
      o_tx.valid = r_valid;
      o_tx.last  = r_valid;      // Single-beat completion
      o_tx.hdr   = r_hdr;
      o_tx.data  = r_data;
   end

   // --------------------------------------------------------------------------
   // Receive ready
   // --------------------------------------------------------------------------
   // A beat taken now strobes next cycle, so the slot must be free by then.
   // A read strobe this cycle fills the slot at this edge, hence the hold.
   assign o_rx_ready = r_live & ~i_req.rd & (~r_valid | i_tx_ready);

endmodule

//--- src/he_null_top.sv
// Host-to-card MMIO endpoint for PF 3 / VF 0; no DMA, no interrupts, single-beat payloads
`timescale 1ns/1ps

module he_null_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  he_null_pkg::mmio_rx_beat_t i_rx,
   output logic                       o_rx_ready,
   output he_null_pkg::mmio_cpl_t     o_tx,
   input  logic                       i_tx_ready,
   input  logic                       i_flr_rst_n,
   output logic                       o_flr_ack
);
   import he_null_pkg::*;

   mmio_req_t     req;
   mmio_cpl_hdr_t cpl_hdr;
   logic [63:0]   rd_data;

   mmio_rx_unpack u_rx_unpack (
      .clk        (clk),
      .rst_n      (rst_n),
      .i_rx       (i_rx),
      .i_rx_ready (o_rx_ready),
      .o_req      (req)
   );

   // CSR space and header builder work side by side on the same request
   mmio_csr_file u_csr_file (
      .clk         (clk),
      .rst_n       (rst_n),
      .i_req       (req),
      .i_flr_rst_n (i_flr_rst_n),
      .o_rd_data   (rd_data),
      .o_flr_ack   (o_flr_ack)
   );

   mmio_cpl_hdr_gen u_cpl_hdr_gen (
      .i_req     (req),
      .o_cpl_hdr (cpl_hdr)
   );

   mmio_tx_stage u_tx_stage (
      .clk        (clk),
      .rst_n      (rst_n),
      .i_req      (req),
      .i_cpl_hdr  (cpl_hdr),
      .i_rd_data  (rd_data),
      .i_tx_ready (i_tx_ready),
      .o_tx       (o_tx),
      .o_rx_ready (o_rx_ready)
   );

endmodule

//--- testbench/he_null_properties.sv
// Stream-port rules of he_null_top, all disabled while rst_n is low
`timescale 1ns/1ps

module he_null_properties (
   input logic                   clk,
   input logic                   rst_n,
   input he_null_pkg::mmio_cpl_t o_tx,
   input logic                   i_tx_ready,
   input logic                   o_rx_ready,
   input logic                   o_flr_ack
);

   // -------------------------------------------------------------------------
   // Output completion slot
   // -------------------------------------------------------------------------
   property p_tx_hold;
      @(posedge clk) disable iff (!rst_n)
         (o_tx.valid && !i_tx_ready) |=> (o_tx.valid && $stable(o_tx));
   endproperty

   property p_rx_stall;
      @(posedge clk) disable iff (!rst_n)
         (o_tx.valid && !i_tx_ready) |-> !o_rx_ready;
   endproperty

   // Ack is a single-cycle pulse
   property p_flr_pulse;
      @(posedge clk) disable iff (!rst_n)
         o_flr_ack |=> !o_flr_ack;
   endproperty

   a_tx_hold:   assert property (p_tx_hold)   else $error("o_tx changed while stalled");
   a_rx_stall:  assert property (p_rx_stall)  else $error("o_rx_ready high while o_tx stalled");
   a_flr_pulse: assert property (p_flr_pulse) else $error("o_flr_ack longer than one cycle");

endmodule

bind he_null_top he_null_properties u_properties (
   .clk        (clk),
   .rst_n      (rst_n),
   .o_tx       (o_tx),
   .i_tx_ready (i_tx_ready),
   .o_rx_ready (o_rx_ready),
   .o_flr_ack  (o_flr_ack)
);

//--- testbench/he_null_tb.sv
// Random single-beat MMIO traffic checked against a CSR model; run length set by NUM_REQ
`timescale 1ns/1ps

module he_null_tb;
   import he_null_pkg::*;

   localparam int NUM_REQ     = 600;
   localparam int CYCLE_LIMIT = 4 * NUM_REQ + 200;

   logic          clk;
   logic          rst_n;
   mmio_rx_beat_t rx;
   logic          rx_ready;
   mmio_cpl_t     tx;
   logic          tx_ready;
   logic          flr_rst_n;
   logic          flr_ack;

   integer        seed;
   int            cycles;
   int            sent;
   logic          taken;          // Current beat accepted at the coming edge
   logic          next_sop;
   logic [11:0]   beat_dw;        // Dword address of the beat on i_rx
   logic          beat_hit;
   logic [63:0]   m_scratch;      // Model scratchpad
   logic [31:0]   m_debug;
   logic [3:0]    flr_hist;       // Driven reset values, newest in bit 0
   mmio_cpl_hdr_t exp_hdr_q[$];
   logic [63:0]   exp_data_q[$];

   he_null_top UUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .i_rx        (rx),
      .o_rx_ready  (rx_ready),
      .o_tx        (tx),
      .i_tx_ready  (tx_ready),
      .i_flr_rst_n (flr_rst_n),
      .o_flr_ack   (flr_ack)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         abort_run($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
      end
   end

   // -------------------------------------------------------------------------
   // Helpers and compare tasks
   // -------------------------------------------------------------------------
   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_cpl_hdr(input mmio_cpl_hdr_t got, input mmio_cpl_hdr_t want);
      if (got !== want) begin
         abort_run($sformatf("** Error at %0t ns: completion header %h, expected %h",
                             $time, got, want));
      end
   endtask

   task automatic check_rd_data(input logic [63:0] got, input logic [63:0] want);
      if (got !== want) begin
         abort_run($sformatf("** Error at %0t ns: read data %h, expected %h", $time, got, want));
      end
   endtask

   task automatic check_flr_ack(input logic got, input logic want);
      if (got !== want) begin
         abort_run($sformatf("** Error at %0t ns: flr ack %b, expected %b", $time, got, want));
      end
   endtask

   // -------------------------------------------------------------------------
   // Stimulus
   // -------------------------------------------------------------------------
   task automatic make_beat();
      logic [31:0] r;
      logic [13:0] off;
      r = next_rand();
      rx.hdr  = {next_rand(), next_rand(), next_rand(), next_rand(), next_rand(), next_rand()};
      rx.data = {next_rand(), next_rand()};
      rx.valid = 1'b1;
      rx.last  = (r[3:0] != 4'h0);                 // Now and then a two-beat packet
      case (r[5:4])
         2'd0: rx.hdr.req_code = REQ_PU_RD;
         2'd1: rx.hdr.req_code = REQ_PU_WR;
         2'd2: rx.hdr.req_code = REQ_DM_RD;
         2'd3: rx.hdr.req_code = REQ_DM_WR;
      endcase
      rx.hdr.length = r[6] ? 10'd2 : 10'd1;
      if (!r[7]) begin
         off = {9'h0, r[9:8], 3'b000};              // One of the four CSRs
      end else begin
         off = {r[20:10], 3'b000};
         if (off[13:5] == 9'h0) off[5] = 1'b1;      // Push it past the map
      end
      beat_dw = {off[13:3], r[21]};
      if (rx.hdr.req_code == REQ_PU_RD || rx.hdr.req_code == REQ_PU_WR) begin
         rx.hdr.addr.pu.dw_addr = beat_dw;
      end else begin
         rx.hdr.addr.dm.dw_addr = beat_dw;
      end
      beat_hit = (r[24:22] != 3'b000);
      rx.hdr.vf_active = r[25];
      if (r[25]) begin
         rx.hdr.vf_num = beat_hit ? VF_ID : (r[10:0] | 11'd1);
      end else begin
         rx.hdr.pf_num = beat_hit ? PF_ID : (PF_ID ^ {r[27:26], 1'b1});
      end
   endtask

   // Reference model, updated at each accepted beat
   task automatic model_accept();
      logic [13:0]   off;
      logic          up;
      logic          sop;
      logic [63:0]   word;
      mmio_cpl_hdr_t h;
      sop      = next_sop;
      next_sop = rx.last;
      off = {beat_dw[11:1], 3'b000};
      up  = (rx.hdr.length == 10'd1) && beat_dw[0];
      if (!sop || !beat_hit) return;
      if (rx.hdr.req_code == REQ_PU_RD || rx.hdr.req_code == REQ_DM_RD) begin
         if (off > CSR_SCRATCH) begin
            word = {m_debug, 18'h0, off};           // Debug word over the offset
         end else begin
            case (off)
               CSR_DFH:    word = FEATURE_DFH_WORD;
               CSR_GUID_L: word = NULL_GUID_L;
               CSR_GUID_H: word = NULL_GUID_H;
               default:    word = m_scratch;
            endcase
            if (up) word = {32'h0, word[63:32]};
         end
         h            = '0;
         h.cpl_code   = CPL_DM;
         h.length     = (rx.hdr.length == 10'd1) ? 10'd1 : 10'd2;
         h.byte_count = (rx.hdr.length == 10'd1) ? 12'd4 : 12'd8;
         h.tag        = rx.hdr.tag;
         h.req_id     = rx.hdr.req_id;
         h.cmpl_id    = {1'b0, VF_ID, rx.hdr.vf_active, PF_ID};
         h.pf_num     = PF_ID;
         h.vf_num     = VF_ID;
         h.vf_active  = rx.hdr.vf_active;
         h.tc         = rx.hdr.tc;
         h.attr       = rx.hdr.attr;
         h.lower_addr = {2'b00, beat_dw, 2'b00};
         exp_hdr_q.push_back(h);
         exp_data_q.push_back(word);
      end else if (off == CSR_SCRATCH) begin
         m_scratch = up ? {2{rx.data[31:0]}} : rx.data;
      end else begin
         m_scratch = 64'h0000_0000_aaaa_aaaa;
         m_debug   = 32'hbbbb_bbbb;
      end
   endtask

   task automatic take_completion();
      if (exp_hdr_q.size() == 0) begin
         abort_run("A completion came out with no read outstanding");
      end else if (!tx.last) begin
         abort_run("A completion beat came out without last set");
      end else begin
         check_cpl_hdr(tx.hdr, exp_hdr_q.pop_front());
         check_rd_data(tx.data, exp_data_q.pop_front());
      end
   endtask

   // One clock: drive at the falling edge, sample 1 ns before the rising edge
   task automatic step_cycle(input logic feed);
      logic [31:0] r;
      @(negedge clk);
      r = next_rand();
      if (!rx.valid || taken) begin
         if (feed && sent < NUM_REQ && r[1:0] != 2'b00) begin
            make_beat();
            sent++;
         end else begin
            rx.valid = 1'b0;
         end
      end
      tx_ready = (r[3:2] != 2'b00);
      if (flr_rst_n) flr_rst_n = (r[9:4] != 6'h0);
      else flr_rst_n = (r[11:10] != 2'b00);
      flr_hist = {flr_hist[2:0], flr_rst_n};
      #1;
      taken = rx.valid && rx_ready;
      if (taken) model_accept();
      if (tx.valid && tx_ready) take_completion();
      check_flr_ack(flr_ack, flr_hist[3] & ~flr_hist[2]);
   endtask

   // -------------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------------
   initial begin
      seed      = 32'ha19e;
      clk       = 1'b0;
      rst_n     = 1'b0;
      rx        = '0;
      tx_ready  = 1'b0;
      flr_rst_n = 1'b1;
      cycles    = 0;
      sent      = 0;
      taken     = 1'b0;
      next_sop  = 1'b1;
      m_scratch = '0;
      m_debug   = 32'hdead_beef;
      flr_hist  = 4'hf;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      while (sent < NUM_REQ || (rx.valid && !taken)) step_cycle(1'b1);
      while (exp_hdr_q.size() != 0) step_cycle(1'b0);
      repeat (8) step_cycle(1'b0);          // Catch stray completions

      // Idle endpoint has an empty slot and takes requests again
      if (rx_ready === 1'b1 && tx.valid === 1'b0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         abort_run($sformatf("Endpoint not idle at the end: o_rx_ready %b, o_tx valid %b",
                             rx_ready, tx.valid));
      end
   end

endmodule

//--- list.f
src/he_null_pkg.sv
src/mmio_rx_unpack.sv
src/mmio_csr_file.sv
src/mmio_cpl_hdr_gen.sv
src/mmio_tx_stage.sv
src/he_null_top.sv
testbench/he_null_properties.sv
testbench/he_null_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
   --top-module he_null_tb -f list.f \
   --Mdir obj_dir -o he_null_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/he_null_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

echo "Simulation finished"
exit 0
